// ==== hw/arcade_ctrl_pkg.sv ====
package arcade_ctrl_pkg;

	// bit positions in the 32-bit status word
	localparam int st_reset       = 0;
	localparam int st_rotate      = 2;
	localparam int st_overlay_off = 5;
	localparam int st_reset_menu  = 6;

	// bit positions in a joystick byte
	localparam int joy_right = 0;
	localparam int joy_left  = 1;
	localparam int joy_down  = 2;
	localparam int joy_up    = 3;
	localparam int joy_fire  = 4;

	typedef enum logic [7:0] {
		key_start1 = 8'h05, // F1
		key_start2 = 8'h06, // F2
		key_fire   = 8'h29, // space
		key_left   = 8'h6B,
		key_down   = 8'h72,
		key_right  = 8'h74,
		key_up     = 8'h75,
		key_coin   = 8'h76  // ESC
	} scancode_e;

	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic coin;
		logic start1;
		logic start2;
		logic fire;
		logic spare;
	} kbd_buttons_t;

	typedef struct packed {
		logic [2:0] unused;
		logic       fire;
		logic       up;
		logic       down;
		logic       left;
		logic       right;
	} joystick_t;

	typedef struct packed {
		logic coin;
		logic start1;
		logic start2;
		logic fire;
		logic left;
		logic right;
	} cab_controls_t;

	typedef struct packed {
		logic game_reset;
		logic rotate;
		logic overlay_on;
	} cab_config_t;

endpackage

// ==== hw/arcade_video_pkg.sv ====
package arcade_video_pkg;

	localparam int x_width = 9;
	localparam int y_width = 8;

	// inclusive limits of the cellophane bands
	localparam logic [y_width-1:0] red_y_lo   = 8'd32;
	localparam logic [y_width-1:0] red_y_hi   = 8'd63;
	localparam logic [y_width-1:0] green_y_lo = 8'd184;
	localparam logic [y_width-1:0] green_y_hi = 8'd239;

	// base strip below the green band only covers part of the line
	localparam logic [x_width-1:0] base_x_lo = 9'd16;
	localparam logic [x_width-1:0] base_x_hi = 9'd133;

	typedef struct packed {
		logic r;
		logic g;
		logic b;
	} pixel_rgb_t;

	typedef struct packed {
		logic [x_width-1:0] x;
		logic [y_width-1:0] y;
	} beam_pos_t;

	localparam pixel_rgb_t rgb_black = '{r: 1'b0, g: 1'b0, b: 1'b0};
	localparam pixel_rgb_t rgb_white = '{r: 1'b1, g: 1'b1, b: 1'b1};
	localparam pixel_rgb_t rgb_red   = '{r: 1'b1, g: 1'b0, b: 1'b0};
	localparam pixel_rgb_t rgb_green = '{r: 1'b0, g: 1'b1, b: 1'b0};

endpackage

// ==== hw/key_decoder.sv ====
`timescale 1ns/1ps

module key_decoder (
	input  logic                          clk_mist,
	input  logic                          rst_n,
	input  logic                          key_strobe,
	input  logic                          key_pressed,
	input  arcade_ctrl_pkg::scancode_e    key_code,
	output arcade_ctrl_pkg::kbd_buttons_t kbd
);

	// make sets a key, break clears it; unmapped codes fall through
	always_ff @(posedge clk_mist) begin
		if (!rst_n) begin
			kbd <= '0;
		end else if (key_strobe) begin
			case (key_code)
				arcade_ctrl_pkg::key_up: begin
					kbd.up <= key_pressed;
				end
				arcade_ctrl_pkg::key_down: begin
					kbd.down <= key_pressed;
				end
				arcade_ctrl_pkg::key_left: begin
					kbd.left <= key_pressed;
				end
				arcade_ctrl_pkg::key_right: begin
					kbd.right <= key_pressed;
				end
				arcade_ctrl_pkg::key_coin: begin
					kbd.coin <= key_pressed; // ESC
				end
				arcade_ctrl_pkg::key_start1: begin
					kbd.start1 <= key_pressed; // F1
				end
				arcade_ctrl_pkg::key_start2: begin
					kbd.start2 <= key_pressed; // F2
				end
				arcade_ctrl_pkg::key_fire: begin
					kbd.fire <= key_pressed; // space
				end
				default: begin
					kbd <= kbd; // unknown code holds the state
				end
			endcase
		end
	end

endmodule

// ==== hw/control_mapper.sv ====
`timescale 1ns/1ps

module control_mapper (
	input  logic                           clk_mist,
	input  logic                           rst_n,
	input  arcade_ctrl_pkg::kbd_buttons_t  kbd,
	input  arcade_ctrl_pkg::joystick_t     joystick_0,
	input  arcade_ctrl_pkg::joystick_t     joystick_1,
	input  logic [31:0]                    status,
	input  logic [1:0]                     buttons,
	output arcade_ctrl_pkg::cab_controls_t controls,
	output arcade_ctrl_pkg::cab_config_t   cfg,
	output logic                           game_rst_n
);

	logic [7:0] joy_any;
	logic dir_up;
	logic dir_down;
	logic dir_left;
	logic dir_right;
	arcade_ctrl_pkg::cab_controls_t controls_d;
	arcade_ctrl_pkg::cab_config_t   cfg_d;

	assign joy_any = joystick_0 | joystick_1; // either stick

	assign dir_up    = kbd.up    | joy_any[arcade_ctrl_pkg::joy_up];
	assign dir_down  = kbd.down  | joy_any[arcade_ctrl_pkg::joy_down];
	assign dir_left  = kbd.left  | joy_any[arcade_ctrl_pkg::joy_left];
	assign dir_right = kbd.right | joy_any[arcade_ctrl_pkg::joy_right];

	always_comb begin
		cfg_d.game_reset = status[arcade_ctrl_pkg::st_reset] |
			status[arcade_ctrl_pkg::st_reset_menu] |
			buttons[1]; // board reset button
		cfg_d.rotate     = status[arcade_ctrl_pkg::st_rotate];
		cfg_d.overlay_on = ~status[arcade_ctrl_pkg::st_overlay_off];
	end

	always_comb begin
		controls_d.coin   = kbd.coin;
		controls_d.start1 = kbd.start1;
		controls_d.start2 = kbd.start2;
		controls_d.fire   = kbd.fire | joy_any[arcade_ctrl_pkg::joy_fire];
		if (cfg_d.rotate) begin
			controls_d.left  = dir_left;
			controls_d.right = dir_right;
		end else begin
			// sideways monitor so up/down move the cannon
			controls_d.left  = dir_up;
			controls_d.right = dir_down;
		end
	end

	always_ff @(posedge clk_mist) begin
		if (!rst_n) begin
			controls <= '0;
			cfg      <= '{game_reset: 1'b0, rotate: 1'b0, overlay_on: 1'b1};
		end else begin
			controls <= controls_d;
			cfg      <= cfg_d;
		end
	end

	assign game_rst_n = ~cfg.game_reset;

endmodule

// ==== hw/video_overlay.sv ====
`timescale 1ns/1ps

module video_overlay (
	input  logic                         clk_mist,
	input  logic                         rst_n,
	input  logic                         pix_ce,
	input  logic                         video,
	input  logic                         hsync,
	input  logic                         vsync,
	input  arcade_ctrl_pkg::cab_config_t cfg,
	output arcade_video_pkg::pixel_rgb_t rgb,
	output logic                         hsync_out,
	output logic                         vsync_out
);

	arcade_video_pkg::beam_pos_t  pos;
	arcade_video_pkg::pixel_rgb_t lit_rgb;
	logic hs_rise;
	logic vs_rise;
	logic in_red;
	logic in_green;
	logic in_base;

	// delayed syncs double as the previous levels
	assign hs_rise = hsync & ~hsync_out;
	assign vs_rise = vsync & ~vsync_out;

	always_ff @(posedge clk_mist) begin
		if (!rst_n) begin
			hsync_out <= 1'b0;
			vsync_out <= 1'b0;
		end else begin
			hsync_out <= hsync;
			vsync_out <= vsync;
		end
	end

	always_ff @(posedge clk_mist) begin
		if (!rst_n) begin
			pos <= '0;
		end else begin
			if (hs_rise) begin
				pos.x <= '0;
			end else if (pix_ce) begin
				pos.x <= pos.x + 1'b1;
			end
			if (vs_rise) begin
				pos.y <= '0;
			end else if (hs_rise) begin
				pos.y <= pos.y + 1'b1;
			end
		end
	end

	assign in_red = (pos.y >= arcade_video_pkg::red_y_lo) &&
		(pos.y <= arcade_video_pkg::red_y_hi);
	assign in_green = (pos.y >= arcade_video_pkg::green_y_lo) &&
		(pos.y <= arcade_video_pkg::green_y_hi);
	assign in_base = (pos.y > arcade_video_pkg::green_y_hi) &&
		(pos.x >= arcade_video_pkg::base_x_lo) &&
		(pos.x <= arcade_video_pkg::base_x_hi); // bases and reserve cannons

	always_comb begin
		lit_rgb = arcade_video_pkg::rgb_white;
		if (cfg.overlay_on) begin
			if (in_red) begin
				lit_rgb = arcade_video_pkg::rgb_red;
			end else if (in_green || in_base) begin
				lit_rgb = arcade_video_pkg::rgb_green;
			end
		end
	end

	always_ff @(posedge clk_mist) begin
		if (!rst_n) begin
			rgb <= arcade_video_pkg::rgb_black;
		end else if (video) begin
			rgb <= lit_rgb;
		end else begin
			rgb <= arcade_video_pkg::rgb_black;
		end
	end

endmodule

// ==== hw/arcade_io_top.sv ====
`timescale 1ns/1ps

module arcade_io_top (
	input  logic                           clk_mist,
	input  logic                           rst_n,
	input  logic                           key_strobe,
	input  logic                           key_pressed,
	input  logic [7:0]                     key_code,
	input  arcade_ctrl_pkg::joystick_t     joystick_0,
	input  arcade_ctrl_pkg::joystick_t     joystick_1,
	input  logic [31:0]                    status,
	input  logic [1:0]                     buttons,
	input  logic                           video,
	input  logic                           hsync,
	input  logic                           vsync,
	input  logic                           pix_ce,
	output arcade_ctrl_pkg::cab_controls_t controls,
	output logic                           game_rst_n,
	output arcade_video_pkg::pixel_rgb_t   rgb,
	output logic                           hsync_out,
	output logic                           vsync_out
);

	arcade_ctrl_pkg::kbd_buttons_t kbd;
	arcade_ctrl_pkg::cab_config_t  cfg;

	key_decoder i_key_decoder (
		.clk_mist    (clk_mist),
		.rst_n       (rst_n),
		.key_strobe  (key_strobe),
		.key_pressed (key_pressed),
		.key_code    (arcade_ctrl_pkg::scancode_e'(key_code)), // raw code from the keyboard
		.kbd         (kbd)
	);

	control_mapper i_control_mapper (
		.clk_mist   (clk_mist),
		.rst_n      (rst_n),
		.kbd        (kbd),
		.joystick_0 (joystick_0),
		.joystick_1 (joystick_1),
		.status     (status),
		.buttons    (buttons),
		.controls   (controls),
		.cfg        (cfg),
		.game_rst_n (game_rst_n)
	);

	video_overlay i_video_overlay (
		.clk_mist  (clk_mist),
		.rst_n     (rst_n),
		.pix_ce    (pix_ce),
		.video     (video),
		.hsync     (hsync),
		.vsync     (vsync),
		.cfg       (cfg),
		.rgb       (rgb),
		.hsync_out (hsync_out),
		.vsync_out (vsync_out)
	);

endmodule

// ==== dv/tb_arcade_io.sv ====
`timescale 1ns/1ps

module tb_arcade_io;

	localparam string stim_path = "dv/arcade_io_stim.txt";

	typedef logic [5:0][31:0] fields_t;

	logic                           clk_mist;
	logic                           rst_n;
	logic                           key_strobe;
	logic                           key_pressed;
	logic [7:0]                     key_code;
	arcade_ctrl_pkg::joystick_t     joystick_0;
	arcade_ctrl_pkg::joystick_t     joystick_1;
	logic [31:0]                    status;
	logic [1:0]                     buttons;
	logic                           video;
	logic                           hsync;
	logic                           vsync;
	logic                           pix_ce;
	arcade_ctrl_pkg::cab_controls_t controls;
	logic                           game_rst_n;
	arcade_video_pkg::pixel_rgb_t   rgb;
	logic                           hsync_out;
	logic                           vsync_out;

	byte     rec_op[$];
	fields_t rec_fields[$];
	string   rec_name[$];

	int cycle_count = 0;
	int cycle_limit = 0;
	int checks_done = 0;

	arcade_video_pkg::beam_pos_t model_pos; // beam position as the core would see it
	arcade_video_pkg::beam_pos_t shown_pos; // position of the last driven pixel
	logic shown_video;
	logic prev_hs;
	logic prev_vs;

	arcade_io_top i_dut (.*);

	initial begin
		clk_mist = 1'b0;
		forever #2 clk_mist = ~clk_mist;
	end

	always @(posedge clk_mist) begin
		cycle_count++;
		if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
			$display("simulation timed out after %0d cycles", cycle_count);
			abort_run();
		end
	end

	task automatic abort_run();
		$display("Testbench failed");
		$fatal(1, "run stopped at first failure");
	endtask

	task automatic check_controls(input string name, input arcade_ctrl_pkg::cab_controls_t exp,
			input arcade_ctrl_pkg::cab_controls_t act);
		checks_done++;
		if (act !== exp) begin
			$display("[ERROR] %s: expected controls %b, actual %b", name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_pixel(input string name, input arcade_video_pkg::pixel_rgb_t exp,
			input arcade_video_pkg::pixel_rgb_t act);
		checks_done++;
		if (act !== exp) begin
			$display("[ERROR] %s: expected rgb %b, actual %b", name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_reset(input string name, input logic exp, input logic act);
		checks_done++;
		if (act !== exp) begin
			$display("[ERROR] %s: expected game_rst_n %b, actual %b", name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_syncs(input string name, input logic [1:0] exp, input logic [1:0] act);
		checks_done++;
		if (act !== exp) begin
			$display("[ERROR] %s: expected hsync/vsync %b, actual %b", name, exp, act);
			abort_run();
		end
	endtask

	// cellophane band rule for a lit pixel
	function automatic arcade_video_pkg::pixel_rgb_t band_colour(
			input arcade_video_pkg::beam_pos_t pos, input logic overlay_on);
		arcade_video_pkg::pixel_rgb_t colour;
		colour = 3'b111;
		if (overlay_on) begin
			if (pos.y >= arcade_video_pkg::red_y_lo && pos.y <= arcade_video_pkg::red_y_hi) begin
				colour = 3'b100;
			end else if (pos.y >= arcade_video_pkg::green_y_lo &&
					pos.y <= arcade_video_pkg::green_y_hi) begin
				colour = 3'b010;
			end else if (pos.y > arcade_video_pkg::green_y_hi &&
					pos.x >= arcade_video_pkg::base_x_lo &&
					pos.x <= arcade_video_pkg::base_x_hi) begin
				colour = 3'b010; // base strip
			end
		end
		return colour;
	endfunction

	function automatic arcade_video_pkg::pixel_rgb_t expected_pixel(input logic overlay_on);
		arcade_video_pkg::pixel_rgb_t colour;
		colour = 3'b000;
		if (shown_video) begin
			colour = band_colour(shown_pos, overlay_on);
		end
		return colour;
	endfunction

	function automatic int record_cycles(input byte op, input fields_t f);
		int cycles;
		cycles = 0;
		case (op)
			"K", "J", "S": cycles = 1;
			"P": cycles = 2 * int'(f[4]) + int'(f[5]) + 1;
			"W": cycles = int'(f[0]);
			default: cycles = 0;
		endcase
		return cycles;
	endfunction

	task automatic drive_video_cycle(input logic v, input logic h, input logic s, input logic ce);
		logic hs_rise;
		logic vs_rise;
		video = v;
		hsync = h;
		vsync = s;
		pix_ce = ce;
		shown_pos = model_pos; // colour uses the position before this edge
		shown_video = v;
		hs_rise = h & ~prev_hs;
		vs_rise = s & ~prev_vs;
		if (hs_rise) begin
			model_pos.x = '0;
		end else if (ce) begin
			model_pos.x = model_pos.x + 1'b1;
		end
		if (vs_rise) begin
			model_pos.y = '0;
		end else if (hs_rise) begin
			model_pos.y = model_pos.y + 1'b1;
		end
		prev_hs = h;
		prev_vs = s;
		@(negedge clk_mist);
		pix_ce = 1'b0;
	endtask

	// hsync pulses, then pix_ce strobes, then the pixel itself
	task automatic run_pixel(input fields_t f);
		int i;
		for (i = 0; i < int'(f[4]); i++) begin
			drive_video_cycle(1'b0, 1'b1, vsync, 1'b0);
			drive_video_cycle(1'b0, 1'b0, vsync, 1'b0);
		end
		for (i = 0; i < int'(f[5]); i++) begin
			drive_video_cycle(1'b0, hsync, vsync, 1'b1);
		end
		drive_video_cycle(f[0][0], f[1][0], f[2][0], f[3][0]);
	endtask

	task automatic load_stim();
		int fd;
		int n;
		int want;
		int v0, v1, v2, v3, v4, v5;
		int longest;
		string line;
		string name;
		byte op;
		fd = $fopen(stim_path, "r");
		if (fd == 0) begin
			$display("cannot open stimulus file %s", stim_path);
			abort_run();
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() < 2 || line.getc(0) == "#") begin
				continue;
			end
			op = line.getc(0);
			name = "";
			{v0, v1, v2, v3, v4, v5} = '0;
			n = 0;
			want = -1;
			case (op)
				"K", "J", "S": begin
					n = $sscanf(line, "%c %h %h", op, v0, v1);
					want = 3;
				end
				"P": begin
					n = $sscanf(line, "%c %h %h %h %h %d %d", op, v0, v1, v2, v3, v4, v5);
					want = 7;
				end
				"C": begin
					n = $sscanf(line, "%c %h %h %s", op, v0, v1, name);
					want = 4;
				end
				"G": begin
					n = $sscanf(line, "%c %h %s", op, v0, name);
					want = 3;
				end
				"R": begin
					n = $sscanf(line, "%c %h %h %h %s", op, v0, v1, v2, name);
					want = 5;
				end
				"W": begin
					n = $sscanf(line, "%c %d", op, v0);
					want = 2;
				end
				default: want = -1;
			endcase
			if (n != want) begin
				$display("stimulus record cannot be read: %s", line);
				abort_run();
			end
			rec_op.push_back(op);
			rec_fields.push_back({v5, v4, v3, v2, v1, v0});
			rec_name.push_back(name);
		end
		$fclose(fd);
		if (rec_op.size() == 0) begin
			$display("stimulus file %s holds no records", stim_path);
			abort_run();
		end
		longest = 1;
		foreach (rec_op[i]) begin
			if (record_cycles(rec_op[i], rec_fields[i]) > longest) begin
				longest = record_cycles(rec_op[i], rec_fields[i]);
			end
		end
		cycle_limit = rec_op.size() * longest + 100;
	endtask

	task automatic run_record(input int idx);
		fields_t f;
		string name;
		f = rec_fields[idx];
		name = rec_name[idx];
		case (rec_op[idx])
			"K": begin
				key_code = f[0][7:0];
				key_pressed = f[1][0];
				key_strobe = 1'b1;
				@(negedge clk_mist);
				key_strobe = 1'b0;
				key_pressed = ~key_pressed; // don't-care while the strobe is low
			end
			"J": begin
				joystick_0 = f[0][7:0];
				joystick_1 = f[1][7:0];
				@(negedge clk_mist);
			end
			"S": begin
				status = f[0];
				buttons = f[1][1:0];
				@(negedge clk_mist);
			end
			"P": run_pixel(f);
			"C": begin
				check_controls(name, f[0][5:0], controls);
				check_reset(name, f[1][0], game_rst_n);
			end
			"G": check_pixel(name, expected_pixel(f[0][0]), rgb);
			"R": begin
				check_pixel(name, f[0][2:0], rgb);
				check_syncs(name, {f[1][0], f[2][0]}, {hsync_out, vsync_out});
			end
			"W": repeat (f[0]) @(negedge clk_mist);
			default: begin
				$display("unknown stimulus opcode in record %0d", idx);
				abort_run();
			end
		endcase
	endtask

	initial begin
		int idx;
		rst_n = 1'b0;
		key_strobe = 1'b0;
		key_pressed = 1'b0;
		key_code = 8'h00;
		joystick_0 = '0;
		joystick_1 = '0;
		status = '0;
		buttons = '0;
		video = 1'b0;
		hsync = 1'b0;
		vsync = 1'b0;
		pix_ce = 1'b0;
		model_pos = '0;
		shown_pos = '0;
		shown_video = 1'b0;
		prev_hs = 1'b0;
		prev_vs = 1'b0;
		load_stim();
		repeat (3) @(negedge clk_mist);
		rst_n = 1'b1;
		for (idx = 0; idx < rec_op.size(); idx++) begin
			run_record(idx);
		end
		if (checks_done == 0) begin
			$display("stimulus file ran without a single check");
			abort_run();
		end else begin
			$display("Testbench passed");
			$finish;
		end
	end

endmodule

// ==== dv/arcade_io_stim.txt ====
# K code pressed | J joy0 joy1 | S status buttons | W cycles(dec) | C controls rst_n name
# P video hsync vsync pix_ce lines(dec) strobes(dec) | G overlay_on name | R rgb hs vs name
C 00 1 reset_controls
R 0 0 0 reset_video
K 76 1
K 05 1
C 20 1 coin_press
K 06 1
C 30 1 start1_press
K 29 1
C 38 1 start2_press
K 75 1
C 3C 1 fire_key_press
K 72 1
C 3E 1 up_key_to_left
K 11 1
C 3F 1 down_key_to_right
K 76 0
C 3F 1 unknown_code_holds
K 05 0
C 1F 1 coin_release
K 06 0
C 0F 1 start1_release
K 29 0
C 07 1 start2_release
K 75 0
C 03 1 fire_key_release
K 72 0
C 01 1 up_key_release
W 1
C 00 1 down_key_release
S 04 0
K 6B 1
K 74 1
C 02 1 left_key_rotated
W 1
C 03 1 right_key_rotated
K 6B 0
K 74 0
C 01 1 left_key_release
J 02 00
C 02 1 joy0_left_rotated
J 00 01
C 01 1 joy1_right_rotated
J 08 04
C 00 1 rotated_up_down_ignored
S 00 0
C 03 1 joy_up_down_sideways
K 75 1
J 00 04
C 03 1 key_and_joy_merge
K 75 0
J 10 00
C 04 1 joy0_fire
J 00 10
C 04 1 joy1_fire
J 00 00
C 00 1 fire_release
S 01 0
C 00 0 status_reset
S 40 0
C 00 0 menu_reset
S 00 2
C 00 0 button_reset
S 00 0
C 00 1 reset_release
P 0 0 1 0 0 0
R 0 0 1 vsync_delayed
P 1 0 0 0 0 0
G 1 top_white
P 1 0 0 0 32 5
G 1 red_band_top
P 1 0 0 0 31 0
G 1 red_band_bottom
P 1 0 0 0 1 0
G 1 below_red_white
P 0 0 0 0 0 0
R 0 0 0 dark_pixel_black
P 1 0 0 0 120 3
G 1 green_band_top
P 1 0 0 0 55 0
G 1 green_band_bottom
P 1 0 0 0 1 15
G 1 base_left_outside
P 1 0 0 0 0 1
G 1 base_left_edge
P 1 0 0 0 0 117
G 1 base_right_edge
P 1 0 0 0 0 1
G 1 base_right_outside
P 0 1 0 0 0 0
R 0 1 0 hsync_delayed
S 20 0
P 1 0 0 0 0 20
G 0 overlay_off_white
S 00 0
P 1 0 0 0 0 0
G 1 overlay_restored
R 2 0 0 hsync_released

// ==== files.f ====
hw/arcade_ctrl_pkg.sv
hw/arcade_video_pkg.sv
hw/key_decoder.sv
hw/control_mapper.sv
hw/video_overlay.sv
hw/arcade_io_top.sv
dv/tb_arcade_io.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the arcade I/O testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timescale 1ns/1ps --top-module tb_arcade_io \
	-f files.f -o tb_arcade_io
build_status=$?
if [ $build_status -ne 0 ]; then
	echo "verilator build failed with status $build_status"
	exit $build_status
fi

./obj_dir/tb_arcade_io
sim_status=$?
if [ $sim_status -ne 0 ]; then
	echo "simulation ended with status $sim_status"
fi
exit $sim_status
